/* source/cnn_geometry_pkg.sv */
package cnn_geometry_pkg;

	// 3x3 kernel over a single input channel
	localparam int KERNEL_DIM = 3;

	// taps are row-major, tap = row * KERNEL_DIM + col
	localparam int KERNEL_TAPS = KERNEL_DIM * KERNEL_DIM;

	localparam int OUT_CHANNELS = 8;

	// weight address a maps to tap a / OUT_CHANNELS, channel a % OUT_CHANNELS
	localparam int WEIGHT_COUNT = KERNEL_TAPS * OUT_CHANNELS;

	// multiply stage plus adder stage
	localparam int PIPE_LATENCY = 2;

	typedef enum logic [1:0] {
		seq_idle,
		seq_prime,
		seq_emit
	} seq_state_t;

	typedef enum logic [1:0] {
		ld_idle,
		ld_load,
		ld_frozen
	} load_state_t;

endpackage

/* source/cnn_data_pkg.sv */
package cnn_data_pkg;

	typedef logic signed [15:0] pixel_t;
	typedef logic signed [15:0] weight_t;
	typedef logic signed [15:0] bias_t;
	typedef logic signed [15:0] feature_t;

	// row, column or memory address
	typedef logic [15:0] coord_t;

	typedef logic signed [31:0] product_t;

	// nine 32-bit products need four guard bits
	typedef logic signed [35:0] acc_t;

	typedef struct packed
	{
		pixel_t [cnn_geometry_pkg::KERNEL_TAPS-1:0] tap;
	} window_t;

	typedef weight_t [cnn_geometry_pkg::KERNEL_TAPS-1:0][cnn_geometry_pkg::OUT_CHANNELS-1:0]
		kernel_weights_t;

	typedef bias_t [cnn_geometry_pkg::OUT_CHANNELS-1:0] bias_vec_t;

	typedef product_t [cnn_geometry_pkg::KERNEL_TAPS-1:0][cnn_geometry_pkg::OUT_CHANNELS-1:0]
		products_t;

	// channel 0 sits in the low bits of output_data
	typedef feature_t [cnn_geometry_pkg::OUT_CHANNELS-1:0] feature_vec_t;

	// weights are Q7.8
	localparam int FRAC_BITS = 8;

endpackage

/* source/coeff_loader.sv */
`timescale 1ns/100ps
module coeff_loader #(
	parameter int  COUNT   = 8,
	parameter type coeff_t = logic [15:0]
) (
	input  logic                 clk,
	input  logic                 rst,
	input  logic                 store_done,
	input  coeff_t               data,
	output logic                 read_signal,
	output cnn_data_pkg::coord_t read_addr,
	output coeff_t [COUNT-1:0]   coeffs
);
	import cnn_geometry_pkg::*;
	import cnn_data_pkg::*;

	localparam coord_t LAST_ADDR = coord_t'(COUNT - 1);

	load_state_t state_q;
	coord_t      addr_q;

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			state_q <= ld_idle;
			addr_q  <= '0;
			coeffs  <= '0;
		end
		else
		begin
			case (state_q)
				ld_idle:
				begin
					if (store_done)
						state_q <= ld_load;
				end
				ld_load:
				begin
					// new word enters at the top, address 0 drifts down to index 0
					coeffs <= {data, coeffs[COUNT-1:1]};
					if (addr_q == LAST_ADDR)
						state_q <= ld_frozen;
					else
						addr_q <= addr_q + 1'b1;
				end
				// held until the next reset
				ld_frozen: state_q <= ld_frozen;
				default:   state_q <= ld_idle;
			endcase
		end
	end

	assign read_signal = (state_q == ld_load);
	assign read_addr   = addr_q;

	addr_in_range: assert property (@(posedge clk) disable iff (rst)
		read_signal |-> read_addr <= LAST_ADDR);

endmodule

/* source/frame_sequencer.sv */
`timescale 1ns/100ps
module frame_sequencer #(
	parameter int IMG_WIDTH = 32
) (
	input  logic                 clk,
	input  logic                 rst,
	input  logic                 pixel_store_done,
	output logic                 read_pixel_signal,
	output cnn_data_pkg::coord_t read_row_addr,
	output cnn_data_pkg::coord_t read_col_addr,
	output logic                 pixel_valid,
	output logic                 save_enable,
	output cnn_data_pkg::coord_t output_row,
	output cnn_data_pkg::coord_t output_col,
	output logic                 layer1_calculation_done
);
	import cnn_geometry_pkg::*;
	import cnn_data_pkg::*;

	typedef struct packed
	{
		logic   valid;
		logic   last;
		coord_t row;
		coord_t col;
	} out_pos_t;

	localparam coord_t LAST_IDX = coord_t'(IMG_WIDTH - 1);
	localparam coord_t EDGE     = coord_t'(KERNEL_DIM - 1);

	seq_state_t                state_q;
	seq_state_t                state_d;
	coord_t                    row_q;
	coord_t                    col_q;
	logic                      row_end;
	out_pos_t                  pos_now;
	out_pos_t [PIPE_LATENCY:0] pos_pipe_q;

	assign row_end = (col_q == LAST_IDX);

	always_comb
	begin
		state_d = state_q;
		case (state_q)
			seq_idle:
			begin
				if (pixel_store_done)
					state_d = seq_prime;
			end
			// first rows only fill the line buffers
			seq_prime:
			begin
				if (row_end && row_q == EDGE - 1'b1)
					state_d = seq_emit;
			end
			seq_emit:
			begin
				if (row_end && row_q == LAST_IDX)
					state_d = seq_idle;
			end
			default: state_d = seq_idle;
		endcase
	end

	// window for (r,c) completes as pixel (r+2,c+2) is read
	always_comb
	begin
		pos_now.valid = (state_q == seq_emit) && (col_q >= EDGE);
		pos_now.last  = row_end && (row_q == LAST_IDX);
		pos_now.row   = row_q - EDGE;
		pos_now.col   = col_q - EDGE;
	end

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			state_q    <= seq_idle;
			row_q      <= '0;
			col_q      <= '0;
			pos_pipe_q <= '0;
		end
		else
		begin
			state_q <= state_d;
			// stage 0 lines up with the window registers
			pos_pipe_q <= {pos_pipe_q[PIPE_LATENCY-1:0], pos_now};
			if (read_pixel_signal)
			begin
				if (row_end)
				begin
					col_q <= '0;
					row_q <= (row_q == LAST_IDX) ? '0 : row_q + 1'b1;
				end
				else
				begin
					col_q <= col_q + 1'b1;
				end
			end
		end
	end

	assign read_pixel_signal       = (state_q != seq_idle);
	assign read_row_addr           = row_q;
	assign read_col_addr           = col_q;
	assign pixel_valid             = read_pixel_signal;
	assign save_enable             = pos_pipe_q[PIPE_LATENCY].valid;
	assign output_row              = pos_pipe_q[PIPE_LATENCY].row;
	assign output_col              = pos_pipe_q[PIPE_LATENCY].col;
	assign layer1_calculation_done = pos_pipe_q[PIPE_LATENCY].valid
		&& pos_pipe_q[PIPE_LATENCY].last;

	// done marks the final save, nothing follows it
	done_ends_frame: assert property (@(posedge clk) disable iff (rst)
		layer1_calculation_done |-> save_enable ##1 !save_enable);

endmodule

/* source/window_buffer.sv */
`timescale 1ns/100ps
module window_buffer #(
	parameter int IMG_WIDTH = 32
) (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  pixel_valid,
	input  cnn_data_pkg::pixel_t  pixel_data,
	output cnn_data_pkg::window_t window
);
	import cnn_geometry_pkg::*;
	import cnn_data_pkg::*;

	// a pixel leaves a row after KERNEL_DIM shifts, one image row is IMG_WIDTH
	localparam int LINE_DEPTH = IMG_WIDTH - KERNEL_DIM;

	// row KERNEL_DIM-1 is the newest, column 0 the oldest
	pixel_t [KERNEL_DIM-1:0][KERNEL_DIM-1:0] rows_q;
	pixel_t [KERNEL_DIM-2:0][LINE_DEPTH-1:0] line_q;

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			rows_q <= '0;
			line_q <= '0;
		end
		else if (pixel_valid)
		begin
			for (int r = 0; r < KERNEL_DIM; r++)
			begin
				for (int c = 0; c < KERNEL_DIM - 1; c++)
				begin
					rows_q[r][c] <= rows_q[r][c+1];
				end
			end
			rows_q[KERNEL_DIM-1][KERNEL_DIM-1] <= pixel_data;

			// each line buffer links the tail of one row to the head of the row above
			for (int l = 0; l < KERNEL_DIM - 1; l++)
			begin
				line_q[l] <= {rows_q[l+1][0], line_q[l][LINE_DEPTH-1:1]};
				rows_q[l][KERNEL_DIM-1] <= line_q[l][0];
			end
		end
	end

	always_comb
	begin
		for (int r = 0; r < KERNEL_DIM; r++)
		begin
			for (int c = 0; c < KERNEL_DIM; c++)
			begin
				window.tap[r*KERNEL_DIM + c] = rows_q[r][c];
			end
		end
	end

endmodule

/* source/mac_array.sv */
`timescale 1ns/100ps
module mac_array (
	input  logic                          clk,
	input  logic                          rst,
	input  cnn_data_pkg::window_t         window,
	input  cnn_data_pkg::kernel_weights_t weights,
	output cnn_data_pkg::products_t       products
);
	import cnn_geometry_pkg::*;

	// one multiplier per tap and channel, 72 in total
	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			products <= '0;
		end
		else
		begin
			for (int t = 0; t < KERNEL_TAPS; t++)
			begin
				for (int c = 0; c < OUT_CHANNELS; c++)
				begin
					// full 32-bit signed product
					products[t][c] <= $signed(window.tap[t]) * $signed(weights[t][c]);
				end
			end
		end
	end

endmodule

/* source/channel_adder.sv */
`timescale 1ns/100ps
module channel_adder (
	input  logic                       clk,
	input  logic                       rst,
	input  cnn_data_pkg::products_t    products,
	input  cnn_data_pkg::bias_vec_t    biases,
	output cnn_data_pkg::feature_vec_t features
);
	import cnn_geometry_pkg::*;
	import cnn_data_pkg::*;

	acc_t         sum_d    [OUT_CHANNELS];
	acc_t         scaled_d [OUT_CHANNELS];
	feature_vec_t result_d;

	always_comb
	begin
		for (int c = 0; c < OUT_CHANNELS; c++)
		begin
			sum_d[c] = '0;
			for (int t = 0; t < KERNEL_TAPS; t++)
			begin
				sum_d[c] = sum_d[c] + $signed(products[t][c]);
			end
			// drop the weight fraction, keep the sign
			scaled_d[c] = sum_d[c] >>> FRAC_BITS;
			// low 16 bits only, bias add wraps
			result_d[c] = scaled_d[c][$bits(feature_t)-1:0] + biases[c];
		end
	end

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			features <= '0;
		end
		else
		begin
			features <= result_d;
		end
	end

endmodule

/* source/conv_layer1.sv */
`timescale 1ns/100ps
module conv_layer1 #(
	parameter int IMG_WIDTH = 32
) (
	input  logic                       clk,
	input  logic                       rst,
	input  logic                       weight_store_done,
	input  logic                       bias_store_done,
	input  logic                       pixel_store_done,
	input  cnn_data_pkg::pixel_t       pixel_data,
	input  cnn_data_pkg::weight_t      weight_data,
	input  cnn_data_pkg::bias_t        bias_data,
	output logic                       read_pixel_signal,
	output cnn_data_pkg::coord_t       read_row_addr,
	output cnn_data_pkg::coord_t       read_col_addr,
	output logic                       read_weight_signal,
	output cnn_data_pkg::coord_t       read_weight_addr,
	output logic                       read_bias_signal,
	output cnn_data_pkg::coord_t       read_bias_addr,
	output logic                       save_enable,
	output cnn_data_pkg::coord_t       output_row,
	output cnn_data_pkg::coord_t       output_col,
	output cnn_data_pkg::feature_vec_t output_data,
	output logic                       layer1_calculation_done
);
	import cnn_geometry_pkg::*;
	import cnn_data_pkg::*;

	kernel_weights_t weights;
	bias_vec_t       biases;
	logic            pixel_valid;
	window_t         window;
	products_t       products;

	// weight address order matches the tap-major, channel-minor layout
	coeff_loader #(.COUNT(WEIGHT_COUNT), .coeff_t(weight_t)) i_weight_loader (
		.clk        (clk),
		.rst        (rst),
		.store_done (weight_store_done),
		.data       (weight_data),
		.read_signal(read_weight_signal),
		.read_addr  (read_weight_addr),
		.coeffs     (weights)
	);

	coeff_loader #(.COUNT(OUT_CHANNELS), .coeff_t(bias_t)) i_bias_loader (
		.clk        (clk),
		.rst        (rst),
		.store_done (bias_store_done),
		.data       (bias_data),
		.read_signal(read_bias_signal),
		.read_addr  (read_bias_addr),
		.coeffs     (biases)
	);

	frame_sequencer #(.IMG_WIDTH(IMG_WIDTH)) i_frame_sequencer (
		.clk                    (clk),
		.rst                    (rst),
		.pixel_store_done       (pixel_store_done),
		.read_pixel_signal      (read_pixel_signal),
		.read_row_addr          (read_row_addr),
		.read_col_addr          (read_col_addr),
		.pixel_valid            (pixel_valid),
		.save_enable            (save_enable),
		.output_row             (output_row),
		.output_col             (output_col),
		.layer1_calculation_done(layer1_calculation_done)
	);

	window_buffer #(.IMG_WIDTH(IMG_WIDTH)) i_window_buffer (
		.clk        (clk),
		.rst        (rst),
		.pixel_valid(pixel_valid),
		.pixel_data (pixel_data),
		.window     (window)
	);

	mac_array i_mac_array (
		.clk     (clk),
		.rst     (rst),
		.window  (window),
		.weights (weights),
		.products(products)
	);

	channel_adder i_channel_adder (
		.clk     (clk),
		.rst     (rst),
		.products(products),
		.biases  (biases),
		.features(output_data)
	);

endmodule

/* testbench/conv_tb_checks.svh */
`ifndef CONV_TB_CHECKS_SVH
`define CONV_TB_CHECKS_SVH

// expected features for the window whose top left pixel is (row, col)
function automatic feature_vec_t ref_feature(input int row, input int col);
	feature_vec_t result;
	acc_t         acc;
	acc_t         scaled;
	product_t     prod;
	int           tap;
	for (int ch = 0; ch < OUT_CHANNELS; ch++)
	begin
		acc = '0;
		for (int kr = 0; kr < KERNEL_DIM; kr++)
		begin
			for (int kc = 0; kc < KERNEL_DIM; kc++)
			begin
				tap  = kr * KERNEL_DIM + kc;
				prod = pixel_mem[(row + kr) * IMG_WIDTH + col + kc]
					* weight_mem[tap * OUT_CHANNELS + ch];
				acc  = acc + prod;
			end
		end
		// arithmetic shift, then keep 16 bits and wrap on the bias add
		scaled     = acc >>> FRAC_BITS;
		result[ch] = feature_t'(scaled[15:0]) + bias_mem[ch];
	end
	return result;
endfunction

task automatic compare_feature(input string what, input feature_vec_t expected,
	input feature_vec_t actual);
	check_count++;
	if (actual !== expected)
	begin
		error_count++;
		$display("ERR %s %s: expected %h actual %h", cur_name, what, expected, actual);
	end
endtask

task automatic compare_coord(input string what, input coord_t expected, input coord_t actual);
	check_count++;
	if (actual !== expected)
	begin
		error_count++;
		$display("ERR %s %s: expected %0d actual %0d", cur_name, what, expected, actual);
	end
endtask

task automatic compare_count(input string what, input int expected, input int actual);
	check_count++;
	if (actual != expected)
	begin
		error_count++;
		$display("ERR %s %s: expected %0d actual %0d", cur_name, what, expected, actual);
	end
endtask

task automatic report_failure(input string what);
	error_count++;
	$display("%s: %s", cur_name, what);
endtask

`endif

/* testbench/conv_layer1_tb.sv */
`timescale 1ns/100ps
module conv_layer1_tb;
	import cnn_geometry_pkg::*;
	import cnn_data_pkg::*;

	localparam int IMG_WIDTH = 8;
	localparam int OUT_SIDE  = IMG_WIDTH - KERNEL_DIM + 1;
	localparam int NUM_TESTS = 5;

	typedef enum logic [1:0] {pat_ramp, pat_random, pat_max, pat_alt} pat_kind_t;

	typedef struct packed
	{
		pat_kind_t img;
		pat_kind_t wgt;
		pat_kind_t bias;
	} test_entry_t;

	string       test_names [NUM_TESTS] = '{"ramp_all", "random_all", "max_pos_wrap",
		"alt_sign", "random_img_max_bias"};
	test_entry_t test_table [NUM_TESTS] = '{'{pat_ramp, pat_ramp, pat_ramp},
		'{pat_random, pat_random, pat_random}, '{pat_max, pat_max, pat_max},
		'{pat_alt, pat_alt, pat_ramp}, '{pat_random, pat_alt, pat_max}};
	string       stage_names [3] = '{"weight load", "bias load", "pixel frame"};
	int          stage_limit [3] = '{200, 50, 400};

	logic         clk;
	logic         rst;
	logic         weight_store_done;
	logic         bias_store_done;
	logic         pixel_store_done;
	pixel_t       pixel_data;
	weight_t      weight_data;
	bias_t        bias_data;
	logic         read_pixel_signal;
	coord_t       read_row_addr;
	coord_t       read_col_addr;
	logic         read_weight_signal;
	coord_t       read_weight_addr;
	logic         read_bias_signal;
	coord_t       read_bias_addr;
	logic         save_enable;
	coord_t       output_row;
	coord_t       output_col;
	feature_vec_t output_data;
	logic         layer1_calculation_done;

	pixel_t  pixel_mem  [IMG_WIDTH*IMG_WIDTH];
	weight_t weight_mem [WEIGHT_COUNT];
	bias_t   bias_mem   [OUT_CHANNELS];

	string cur_name;
	int    error_count;
	int    check_count;
	int    weight_reads;
	int    bias_reads;
	int    pixel_reads;
	int    out_count;
	int    done_count;
	int    first_draw;
	bit    timed_out;

	`include "conv_tb_checks.svh"

	conv_layer1 #(.IMG_WIDTH(IMG_WIDTH)) i_conv_layer1 (.*);

	// memories answer in the same cycle as the address
	assign pixel_data = read_pixel_signal
		? pixel_mem[int'(read_row_addr) * IMG_WIDTH + int'(read_col_addr)] : '0;
	assign weight_data = read_weight_signal ? weight_mem[read_weight_addr] : '0;
	assign bias_data   = read_bias_signal ? bias_mem[read_bias_addr] : '0;

	initial
	begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// sample mid cycle, away from the drive point
	always @(negedge clk)
	begin
		if (!rst)
		begin
			if (read_weight_signal)
			begin
				compare_coord("weight addr", coord_t'(weight_reads), read_weight_addr);
				weight_reads++;
			end
			if (read_bias_signal)
			begin
				compare_coord("bias addr", coord_t'(bias_reads), read_bias_addr);
				bias_reads++;
			end
			if (read_pixel_signal)
			begin
				compare_coord("pixel row", coord_t'(pixel_reads / IMG_WIDTH), read_row_addr);
				compare_coord("pixel col", coord_t'(pixel_reads % IMG_WIDTH), read_col_addr);
				pixel_reads++;
			end
			if (save_enable)
			begin
				compare_coord("output row", coord_t'(out_count / OUT_SIDE), output_row);
				compare_coord("output col", coord_t'(out_count % OUT_SIDE), output_col);
				if (output_row < OUT_SIDE && output_col < OUT_SIDE)
					compare_feature("output data", ref_feature(output_row, output_col),
						output_data);
				out_count++;
			end
			if (layer1_calculation_done)
			begin
				done_count++;
				if (!save_enable)
					report_failure("done pulsed without save_enable");
				compare_count("outputs at done", OUT_SIDE * OUT_SIDE, out_count);
			end
		end
	end

	function automatic logic signed [15:0] pattern_value(input pat_kind_t kind, input int idx);
		case (kind)
			pat_ramp:   return 16'(idx * 37 - 300);
			pat_random: return 16'($urandom);
			pat_max:    return 16'sh7fff;
			default:    return 16'((idx % 2 == 1) ? -(idx * 411 + 5) : idx * 263 + 7);
		endcase
	endfunction

	task automatic advance();
		@(posedge clk);
		#2;
	endtask

	function automatic bit stage_busy(input int stage);
		case (stage)
			0:       return weight_reads < WEIGHT_COUNT || read_weight_signal;
			1:       return bias_reads < OUT_CHANNELS || read_bias_signal;
			default: return done_count == 0 || save_enable;
		endcase
	endfunction

	// one store done pulse, then wait for that stage to finish
	task automatic run_stage(input int stage);
		int cycles;
		cycles = 0;
		advance();
		weight_store_done = (stage == 0);
		bias_store_done   = (stage == 1);
		pixel_store_done  = (stage == 2);
		advance();
		weight_store_done = 1'b0;
		bias_store_done   = 1'b0;
		pixel_store_done  = 1'b0;
		while (stage_busy(stage) && cycles < stage_limit[stage])
		begin
			advance();
			cycles++;
		end
		if (stage_busy(stage))
		begin
			report_failure({"timed out waiting for the ", stage_names[stage]});
			timed_out = 1'b1;
		end
	endtask

	task automatic run_test(input int t);
		int start_errors;
		cur_name     = test_names[t];
		start_errors = error_count;
		advance();
		rst = 1'b1;
		for (int i = 0; i < IMG_WIDTH * IMG_WIDTH; i++)
			pixel_mem[i] = pattern_value(test_table[t].img, i);
		for (int i = 0; i < WEIGHT_COUNT; i++)
			weight_mem[i] = pattern_value(test_table[t].wgt, i + 5);
		for (int i = 0; i < OUT_CHANNELS; i++)
			bias_mem[i] = pattern_value(test_table[t].bias, i * 3);
		weight_reads = 0;
		bias_reads   = 0;
		pixel_reads  = 0;
		out_count    = 0;
		done_count   = 0;
		repeat (5) advance();
		rst = 1'b0;
		@(negedge clk);
		if (save_enable || layer1_calculation_done || read_pixel_signal
			|| read_weight_signal || read_bias_signal)
			report_failure("outputs or read strobes not low after reset");
		for (int s = 0; s < 3 && !timed_out; s++)
			run_stage(s);
		// a few idle cycles to catch stray outputs
		repeat (4) advance();
		compare_count("weight reads", WEIGHT_COUNT, weight_reads);
		compare_count("bias reads", OUT_CHANNELS, bias_reads);
		compare_count("pixel reads", IMG_WIDTH * IMG_WIDTH, pixel_reads);
		compare_count("outputs", OUT_SIDE * OUT_SIDE, out_count);
		compare_count("done pulses", 1, done_count);
		if (error_count == start_errors)
			$display("test %s: ok", cur_name);
		else
			$display("test %s: %0d errors", cur_name, error_count - start_errors);
	endtask

	initial
	begin
		first_draw        = $urandom(87);
		error_count       = 0;
		check_count       = 0;
		timed_out         = 1'b0;
		rst               = 1'b1;
		weight_store_done = 1'b0;
		bias_store_done   = 1'b0;
		pixel_store_done  = 1'b0;
		for (int t = 0; t < NUM_TESTS && !timed_out; t++)
			run_test(t);
		$display("tests %0d, checks %0d, errors %0d", NUM_TESTS, check_count, error_count);
		if (error_count == 0 && !timed_out)
			$display("SIMULATION PASSED");
		else
			$display("SIMULATION FAILED");
		$finish;
	end

endmodule

/* compile.f */
source/cnn_geometry_pkg.sv
source/cnn_data_pkg.sv
source/coeff_loader.sv
source/frame_sequencer.sv
source/window_buffer.sv
source/mac_array.sv
source/channel_adder.sv
source/conv_layer1.sv
+incdir+testbench
testbench/conv_layer1_tb.sv
